/* src.f */
hw/smc_pkg.sv
hw/smc_apb_regs.sv
hw/smc_ahb_slave.sv
hw/smc_strobe_seq.sv
hw/smc_veneer.sv
bench/emi_sram_model.sv
bench/smc_assert.sv
bench/smc_tb.sv

/* bench/smc_tb.sv */
// SMC testbench
`timescale 1ns/1ps

module smc_tb import smc_pkg::*; ();

  typedef struct {
    logic [31:0] addr;
    int          cyc;                   // Data phase length
    int          valid_n;               // smc_valid pulses
    int          busy_n;                // Cycles with smc_busy high
    int          oe_n;                  // Cycles with smc_n_ext_oe low
    logic [1:0]  resp;
    logic [31:0] rdata;
    logic [31:0] emi_addr;              // smc_addr under chip select
    logic [31:0] emi_data;              // smc_data under write strobe
    logic [3:0]  n_be;
    bit          cs;                    // Chip select seen low
    bit          rd;                    // Read data to compare
  } xfer_t;

  logic        hclk, rst_n;
  logic        psel, penable, pwrite;
  logic [4:0]  paddr;
  logic [31:0] pwdata, prdata;
  logic [31:0] haddr, hwdata, smc_hrdata;
  logic [1:0]  htrans, smc_hresp;
  logic        hsel, hwrite, hready, smc_hready, smc_valid;
  logic [2:0]  hsize;
  logic [31:0] smc_addr, smc_data, data_smc;
  logic [3:0]  smc_n_be, smc_n_we;
  logic        smc_n_cs, smc_n_wr, smc_n_rd, smc_n_ext_oe, smc_busy;

  integer      seed = 46148;
  int          n_checks, n_errors, n_rejects;
  bit          en_model;                // Expected ctrl_en
  int          t_setup, t_rdw, t_wrw, t_hold;
  logic [31:0] shadow [0:1023];         // Expected memory words
  logic [31:0] addr_list [$];           // Word addresses written so far
  xfer_t       exp_q [$];
  xfer_t       obs_q [$];
  event        xfer_done;

  smc_veneer #(.ADDR_W(24)) DUT (.*);

  emi_sram_model u_sram (
    .smc_addr, .smc_data, .smc_n_we, .smc_n_cs, .smc_n_rd, .data_smc
  );

  initial begin
    hclk = 1'b0;
    forever #50 hclk = ~hclk;
  end

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  function automatic int exp_cycles(int setup, int wait_st, int hold);
    return 2 + setup + wait_st + 1 + hold;
  endfunction

  function automatic logic [31:0] exp_read(logic [31:0] addr);
    return shadow[addr[11:2]];          // Merged result of earlier writes
  endfunction

  // Little-endian lanes of one transfer
  function automatic logic [3:0] lane_mask(logic [2:0] size, logic [1:0] off);
    if (size == 3'd0)
      return 4'b0001 << off;
    if (size == 3'd1)
      return off[1] ? 4'b1100 : 4'b0011;
    return 4'b1111;
  endfunction

  task automatic report_mismatch(string msg);
    n_errors++;
    $display("Mismatch at %0t ns: %s", $time, msg);
  endtask

  task automatic check_val(string what, logic [31:0] got, logic [31:0] exp);
    n_checks++;
    if (got !== exp)
      report_mismatch($sformatf("%s got %h expected %h", what, got, exp));
  endtask

  task automatic timeout_fail(string what);
    $display("Timeout at %0t ns while waiting for %s", $time, what);
    $display("=== FAIL ===");
    $finish;
  endtask

  // ----------------------------------------
  // APB bus
  // ----------------------------------------
  task automatic apb_write(logic [4:0] addr, logic [31:0] data);
    @(posedge hclk);
    psel   <= 1'b1;                     // Setup phase
    pwrite <= 1'b1;
    paddr  <= addr;
    pwdata <= data;
    @(posedge hclk);
    penable <= 1'b1;                    // Access phase
    @(posedge hclk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_read(logic [4:0] addr, output logic [31:0] data);
    @(posedge hclk);
    psel  <= 1'b1;
    paddr <= addr;
    @(posedge hclk);
    penable <= 1'b1;
    @(negedge hclk);
    data = prdata;                      // Combinational from paddr
    @(posedge hclk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic set_timing(int s, int r, int w, int h);
    logic [31:0] word;
    logic [31:0] rb;
    word = (h << HOLD_LSB) | (w << WR_WAIT_LSB) | (r << RD_WAIT_LSB) | (s << SETUP_LSB);
    apb_write(REG_TIMING, word);
    t_setup = s;
    t_rdw   = r;
    t_wrw   = w;
    t_hold  = h;
    apb_read(REG_TIMING, rb);
    check_val("timing readback", rb, word);
  endtask

  // ----------------------------------------
  // AHB transfer with expected and observed records
  // ----------------------------------------
  task automatic ahb_xfer(bit wr, logic [31:0] addr, logic [2:0] size, logic [31:0] wdata);
    xfer_t      e;
    xfer_t      o;
    logic [3:0] mask;
    bit         ok;
    ok         = en_model && (size <= 3'd2);
    mask       = lane_mask(size, addr[1:0]);
    e.addr     = addr;
    e.cyc      = ok ? exp_cycles(t_setup, wr ? t_wrw : t_rdw, t_hold) : 2;
    e.valid_n  = 1;
    e.busy_n   = ok ? e.cyc - 2 : 0;   // Setup through hold
    e.oe_n     = (ok && wr) ? e.cyc - 2 : 0;
    e.resp     = ok ? RESP_OKAY : RESP_ERROR;
    e.n_be     = ok ? ~mask : 4'hF;     // Nothing on the EMI when rejected
    e.emi_addr = ok ? (addr & 32'h00FF_FFFF) : 32'h0; // 24-bit EMI address
    e.emi_data = (ok && wr) ? wdata : 32'h0;
    e.cs       = ok;
    e.rd       = ok && !wr;
    e.rdata    = e.rd ? exp_read(addr) : 32'h0;
    if (!ok)
      n_rejects++;
    for (int i = 0; i < 4; i++) begin
      if (ok && wr && mask[i])
        shadow[addr[11:2]][8*i +: 8] = wdata[8*i +: 8];
    end
    exp_q.push_back(e);
    o = '{addr: addr, cyc: 0, valid_n: 0, busy_n: 0, oe_n: 0, resp: 2'b00,
          rdata: 32'h0, emi_addr: 32'h0, emi_data: 32'h0,
          n_be: 4'hF, cs: 1'b0, rd: 1'b0};
    @(posedge hclk);
    haddr  <= addr;                     // Address phase
    htrans <= TRANS_NONSEQ;
    hsel   <= 1'b1;
    hwrite <= wr;
    hsize  <= size;
    @(posedge hclk);
    htrans <= TRANS_IDLE;               // Accepted on this edge
    hsel   <= 1'b0;
    hwdata <= wdata;
    do begin
      @(negedge hclk);
      o.cyc++;
      if (!smc_n_cs) begin
        o.cs       = 1'b1;
        o.n_be     = smc_n_be;
        o.emi_addr = smc_addr;
      end
      if (!smc_n_wr)
        o.emi_data = smc_data;
      if (smc_busy)
        o.busy_n++;
      if (!smc_n_ext_oe)
        o.oe_n++;
      if (smc_valid)
        o.valid_n++;
    end while (!smc_hready && o.cyc < 200);
    if (!smc_hready) begin
      timeout_fail("smc_hready");
    end else begin
      o.resp  = smc_hresp;
      o.rdata = smc_hrdata;
      obs_q.push_back(o);
      -> xfer_done;
    end
  endtask

  // Compares each finished transfer with its expectation
  initial begin : compare
    xfer_t e;
    xfer_t o;
    forever begin
      @(xfer_done);
      while (exp_q.size() > 0 && obs_q.size() > 0) begin
        e = exp_q.pop_front();
        o = obs_q.pop_front();
        n_checks++;
        if (o.cyc != e.cyc)
          report_mismatch($sformatf("addr %h data phase %0d cycles, expected %0d",
                                    e.addr, o.cyc, e.cyc));
        if (o.resp !== e.resp)
          report_mismatch($sformatf("addr %h hresp %b expected %b", e.addr, o.resp, e.resp));
        if (o.valid_n != e.valid_n)
          report_mismatch($sformatf("addr %h smc_valid pulsed %0d times", e.addr, o.valid_n));
        if (o.cs != e.cs)
          report_mismatch($sformatf("addr %h chip select seen %0d, expected %0d",
                                    e.addr, o.cs, e.cs));
        if (o.n_be !== e.n_be)
          report_mismatch($sformatf("addr %h smc_n_be %b expected %b", e.addr, o.n_be, e.n_be));
        if (o.busy_n != e.busy_n)
          report_mismatch($sformatf("addr %h smc_busy high %0d cycles, expected %0d",
                                    e.addr, o.busy_n, e.busy_n));
        if (o.oe_n != e.oe_n)
          report_mismatch($sformatf("addr %h smc_n_ext_oe low %0d cycles, expected %0d",
                                    e.addr, o.oe_n, e.oe_n));
        if (o.emi_addr !== e.emi_addr)
          report_mismatch($sformatf("addr %h smc_addr %h expected %h",
                                    e.addr, o.emi_addr, e.emi_addr));
        if (o.emi_data !== e.emi_data)
          report_mismatch($sformatf("addr %h smc_data %h expected %h",
                                    e.addr, o.emi_data, e.emi_data));
        if (e.rd && o.rdata !== e.rdata)
          report_mismatch($sformatf("addr %h read %h expected %h", e.addr, o.rdata, e.rdata));
      end
    end
  end

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin : main
    logic [31:0] rdat;
    logic [31:0] a;
    logic [2:0]  sz;
    int          r;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    haddr   = '0;
    htrans  = TRANS_IDLE;
    hsel    = 1'b0;
    hwrite  = 1'b0;
    hsize   = SIZE_WORD;
    hwdata  = '0;
    hready  = 1'b1;                     // Single slave so the bus is always ready
    en_model = 1'b1;
    t_setup = 1;                        // Reset timing
    t_rdw   = 2;
    t_wrw   = 1;
    t_hold  = 1;
    rst_n = 1'b0;
    repeat (4) @(posedge hclk);
    rst_n <= 1'b1;

    // Reset state
    apb_read(REG_TIMING, rdat);
    check_val("timing after reset", rdat, TIMING_RST);
    apb_read(REG_CTRL, rdat);
    check_val("ctrl after reset", rdat, 32'h1);
    apb_read(REG_STATUS, rdat);
    check_val("status after reset", rdat, 32'h0);
    apb_read(REG_ERRCNT, rdat);
    check_val("error count after reset", rdat, 32'h0);
    @(negedge hclk);
    check_val("EMI controls idle",
              {smc_n_cs, smc_n_rd, smc_n_wr, smc_n_ext_oe, smc_n_we, smc_n_be}, 12'hFFF);
    check_val("AHB outputs idle", {smc_hready, smc_hresp, smc_valid, smc_busy}, 5'b10000);

    // Word writes then read back
    repeat (8) begin
      a = $random(seed) & 32'h0000_0FFC;
      addr_list.push_back(a);
      ahb_xfer(1'b1, a, SIZE_WORD, $random(seed));
    end
    foreach (addr_list[i])
      ahb_xfer(1'b0, addr_list[i], SIZE_WORD, 32'h0);

    // Byte and halfword lanes
    repeat (12) begin
      r  = $random(seed) & 7;
      a  = addr_list[r] | ($random(seed) & 3);
      sz = $random(seed) & 1;
      if (sz == SIZE_HALF)
        a[0] = 1'b0;                    // Halfwords aligned
      ahb_xfer(1'b1, a, sz, $random(seed));
      ahb_xfer(1'b0, addr_list[r], SIZE_WORD, 32'h0);
    end

    // New timing values
    repeat (4) begin
      set_timing($random(seed) & 3, $random(seed) & 7, $random(seed) & 7, $random(seed) & 3);
      r = $random(seed) & 7;
      ahb_xfer(1'b1, addr_list[r], SIZE_WORD, $random(seed));
      ahb_xfer(1'b0, addr_list[r], SIZE_WORD, 32'h0);
    end

    // Rejected transfers
    apb_write(REG_CTRL, 32'h0);
    en_model = 1'b0;
    ahb_xfer(1'b1, addr_list[0], SIZE_WORD, $random(seed));
    ahb_xfer(1'b0, addr_list[1], SIZE_WORD, 32'h0);
    apb_write(REG_CTRL, 32'h1);
    en_model = 1'b1;
    ahb_xfer(1'b1, addr_list[2], 3'd3 + ($random(seed) & 3), $random(seed));
    ahb_xfer(1'b0, addr_list[3], 3'd7, 32'h0);
    ahb_xfer(1'b0, addr_list[0], SIZE_WORD, 32'h0); // Untouched by rejected write
    apb_read(REG_ERRCNT, rdat);
    check_val("error count", rdat, n_rejects);

    // Counter clear and busy flag
    apb_write(REG_ERRCNT, $random(seed));
    apb_read(REG_ERRCNT, rdat);
    check_val("error count after clear", rdat, 32'h0);
    set_timing(2, 15, 1, 2);
    fork
      ahb_xfer(1'b0, addr_list[4], SIZE_WORD, 32'h0);
      begin
        r = 0;
        while (smc_n_rd && r < 50) begin
          @(negedge hclk);
          r++;
        end
        if (smc_n_rd) begin
          timeout_fail("read strobe");
        end else begin
          apb_read(REG_STATUS, rdat);
          check_val("busy during long read", rdat, 32'h1);
        end
      end
    join
    apb_read(REG_STATUS, rdat);
    check_val("busy when idle", rdat, 32'h0);

    @(posedge hclk);
    n_errors += DUT.u_assert.fail_cnt;
    if (exp_q.size() != 0 || obs_q.size() != 0) begin
      n_errors++;
      $display("Transfer records left unmatched: %0d expected, %0d observed",
               exp_q.size(), obs_q.size());
    end
    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

/* bench/smc_assert.sv */
// SMC bus protocol assertions
`timescale 1ns/1ps

module smc_assert import smc_pkg::*; (
  input logic       hclk,
  input logic       rst_n,
  input logic       smc_n_cs,
  input logic       smc_n_rd,
  input logic       smc_n_wr,
  input logic [3:0] smc_n_we,
  input logic [1:0] smc_hresp
);

  logic strobe_low;                     // Any strobe active
  int   fail_cnt = 0;                   // Failed assertions so far

  assign strobe_low = !smc_n_rd || !smc_n_wr || (smc_n_we != 4'hF);

  // Read and write never overlap
  rd_wr_excl: assert property (@(posedge hclk) disable iff (!rst_n)
    smc_n_rd || smc_n_wr)
    else begin
      fail_cnt++;
      $error("Read and write strobes low together");
    end

  // Strobes only inside chip select
  strobe_in_cs: assert property (@(posedge hclk) disable iff (!rst_n)
    strobe_low |-> !smc_n_cs)
    else begin
      fail_cnt++;
      $error("Strobe low while chip select is high");
    end

  // ERROR lasts two cycles then returns to OKAY
  err_pair: assert property (@(posedge hclk) disable iff (!rst_n)
    $rose(smc_hresp == RESP_ERROR) |=> (smc_hresp == RESP_ERROR) ##1
    (smc_hresp == RESP_OKAY))
    else begin
      fail_cnt++;
      $error("ERROR response not exactly two cycles long");
    end

endmodule

bind smc_veneer smc_assert u_assert (
  .hclk, .rst_n, .smc_n_cs, .smc_n_rd, .smc_n_wr, .smc_n_we, .smc_hresp
);

/* bench/emi_sram_model.sv */
// EMI byte-lane SRAM model
`timescale 1ns/1ps

module emi_sram_model #(
  parameter int AW = 10                 // Word address bits, 4 KB
) (
  input  logic [31:0] smc_addr,
  input  logic [31:0] smc_data,
  input  logic [3:0]  smc_n_we,
  input  logic        smc_n_cs,
  input  logic        smc_n_rd,
  output logic [31:0] data_smc
);

  logic [31:0]   mem [0:(1<<AW)-1];
  logic [AW-1:0] widx;

  assign widx = smc_addr[AW+1:2];       // Word index

  // Lanes follow the bus while their enable is low
  always @(smc_n_we or smc_n_cs or smc_data or widx) begin
    for (int i = 0; i < 4; i++) begin
      if (!smc_n_cs && !smc_n_we[i])
        mem[widx][8*i +: 8] = smc_data[8*i +: 8];
    end
  end

  // Output driven only inside a read strobe
  assign data_smc = (!smc_n_cs && !smc_n_rd) ? mem[widx] : 32'h0;

endmodule

/* hw/smc_veneer.sv */
// Static memory controller top
`timescale 1ns/1ps

module smc_veneer import smc_pkg::*; #(
  parameter int ADDR_W = 24             // EMI address width, 12 to 32
) (
  input  logic        hclk,
  input  logic        rst_n,
  // APB
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [4:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  // AHB-lite
  input  logic [31:0] haddr,
  input  logic [1:0]  htrans,
  input  logic        hsel,
  input  logic        hwrite,
  input  logic [2:0]  hsize,
  input  logic [31:0] hwdata,
  input  logic        hready,
  output logic [31:0] smc_hrdata,
  output logic        smc_hready,
  output logic [1:0]  smc_hresp,
  output logic        smc_valid,
  // EMI
  output logic [31:0] smc_addr,
  output logic [31:0] smc_data,
  input  logic [31:0] data_smc,
  output logic [3:0]  smc_n_be,
  output logic        smc_n_cs,
  output logic [3:0]  smc_n_we,
  output logic        smc_n_wr,
  output logic        smc_n_rd,
  output logic        smc_n_ext_oe,
  output logic        smc_busy
);

  // ----------------------------------------
  // Internal wiring
  // ----------------------------------------
  logic               ctrl_en;
  logic [SETUP_W-1:0] setup_cyc;
  logic [WAIT_W-1:0]  rd_wait;
  logic [WAIT_W-1:0]  wr_wait;
  logic [HOLD_W-1:0]  hold_cyc;
  logic               err_pulse;
  logic               seq_busy;
  logic               cyc_start, cyc_write, cyc_done;
  logic [ADDR_W-1:0]  cyc_addr;
  logic [3:0]         cyc_be;
  logic [31:0]        cyc_wdata, cyc_rdata;

  assign smc_busy = seq_busy;

  smc_apb_regs u_regs (
    .hclk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
    .seq_busy, .err_pulse, .prdata, .ctrl_en,
    .setup_cyc, .rd_wait, .wr_wait, .hold_cyc
  );

  smc_ahb_slave #(.ADDR_W(ADDR_W)) u_ahb (
    .hclk, .rst_n, .haddr, .htrans, .hsel, .hwrite, .hsize, .hwdata, .hready,
    .ctrl_en, .cyc_done, .cyc_rdata,
    .smc_hrdata, .smc_hready, .smc_hresp, .smc_valid,
    .cyc_start, .cyc_write, .cyc_addr, .cyc_be, .cyc_wdata, .err_pulse
  );

  smc_strobe_seq #(.ADDR_W(ADDR_W)) u_seq (
    .hclk, .rst_n, .cyc_start, .cyc_write, .cyc_addr, .cyc_be, .cyc_wdata,
    .setup_cyc, .rd_wait, .wr_wait, .hold_cyc, .data_smc,
    .cyc_done, .cyc_rdata, .seq_busy,
    .smc_addr, .smc_data, .smc_n_be, .smc_n_cs, .smc_n_we,
    .smc_n_wr, .smc_n_rd, .smc_n_ext_oe
  );

endmodule

/* hw/smc_strobe_seq.sv */
// SMC external memory strobe sequencer
`timescale 1ns/1ps

module smc_strobe_seq import smc_pkg::*; #(
  parameter int ADDR_W = 24
) (
  input  logic               hclk,
  input  logic               rst_n,
  input  logic               cyc_start,
  input  logic               cyc_write,
  input  logic [ADDR_W-1:0]  cyc_addr,
  input  logic [3:0]         cyc_be,
  input  logic [31:0]        cyc_wdata,
  input  logic [SETUP_W-1:0] setup_cyc,
  input  logic [WAIT_W-1:0]  rd_wait,
  input  logic [WAIT_W-1:0]  wr_wait,
  input  logic [HOLD_W-1:0]  hold_cyc,
  input  logic [31:0]        data_smc,
  output logic               cyc_done,
  output logic [31:0]        cyc_rdata,
  output logic               seq_busy,
  output logic [31:0]        smc_addr,
  output logic [31:0]        smc_data,
  output logic [3:0]         smc_n_be,
  output logic               smc_n_cs,
  output logic [3:0]         smc_n_we,
  output logic               smc_n_wr,
  output logic               smc_n_rd,
  output logic               smc_n_ext_oe
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_STROBE,
    ST_HOLD
  } state_e;

  state_e             state_q, state_nxt;
  logic [WAIT_W-1:0]  cnt_q, cnt_nxt;  // Cycles left in phase, minus one
  logic [WAIT_W-1:0]  wait_q;          // Strobe length latched at start
  logic [HOLD_W-1:0]  hold_q;
  logic [WAIT_W-1:0]  wait_sel;
  logic               strobe_last;
  logic               active_nxt;
  logic               strobe_nxt;

  assign wait_sel    = cyc_write ? wr_wait : rd_wait;
  assign strobe_last = (state_q == ST_STROBE) && (cnt_q == '0);

  // ----------------------------------------
  // Phase sequencing
  // ----------------------------------------
  always_comb begin
    state_nxt = state_q;
    cnt_nxt   = cnt_q;
    case (state_q)
      ST_IDLE: begin
        if (cyc_start) begin
          if (setup_cyc != '0) begin
            state_nxt = ST_SETUP;
            cnt_nxt   = WAIT_W'(setup_cyc) - 1'b1;
          end else begin
            state_nxt = ST_STROBE;      // No setup, strobe at once
            cnt_nxt   = wait_sel;
          end
        end
      end
      ST_SETUP: begin
        if (cnt_q == '0) begin
          state_nxt = ST_STROBE;
          cnt_nxt   = wait_q;           // wait + 1 strobe cycles
        end else begin
          cnt_nxt = cnt_q - 1'b1;
        end
      end
      ST_STROBE: begin
        if (cnt_q == '0) begin
          if (hold_q != '0) begin
            state_nxt = ST_HOLD;
            cnt_nxt   = WAIT_W'(hold_q) - 1'b1;
          end else begin
            state_nxt = ST_IDLE;
          end
        end else begin
          cnt_nxt = cnt_q - 1'b1;
        end
      end
      ST_HOLD: begin
        if (cnt_q == '0)
          state_nxt = ST_IDLE;
        else
          cnt_nxt = cnt_q - 1'b1;
      end
      default: state_nxt = ST_IDLE;
    endcase
  end

  // Done in last hold cycle, or last strobe cycle with no hold
  assign cyc_done = ((state_q == ST_HOLD) && (cnt_q == '0)) ||
                    (strobe_last && (hold_q == '0));
  assign seq_busy = (state_q != ST_IDLE);

  assign active_nxt = (state_nxt != ST_IDLE);
  assign strobe_nxt = (state_nxt == ST_STROBE);

  // ----------------------------------------
  // Registered EMI controls, all active low
  // ----------------------------------------
  always_ff @(posedge hclk) begin
    if (!rst_n) begin
      state_q      <= ST_IDLE;
      cnt_q        <= '0;
      wait_q       <= '0;
      hold_q       <= '0;
      smc_n_cs     <= 1'b1;
      smc_n_be     <= 4'hF;
      smc_n_we     <= 4'hF;
      smc_n_wr     <= 1'b1;
      smc_n_rd     <= 1'b1;
      smc_n_ext_oe <= 1'b1;
    end else begin
      state_q <= state_nxt;
      cnt_q   <= cnt_nxt;
      if (state_q == ST_IDLE && cyc_start) begin
        wait_q <= wait_sel;             // Timing frozen for this cycle
        hold_q <= hold_cyc;
      end
      smc_n_cs     <= !active_nxt;
      smc_n_be     <= active_nxt ? ~cyc_be : 4'hF;
      smc_n_we     <= (strobe_nxt && cyc_write) ? ~cyc_be : 4'hF;
      smc_n_wr     <= !(strobe_nxt && cyc_write);
      smc_n_rd     <= !(strobe_nxt && !cyc_write);
      smc_n_ext_oe <= !(active_nxt && cyc_write); // Drive bus whole write
    end
  end

  // Address, write data and read capture
  always_ff @(posedge hclk) begin
    if (state_q == ST_IDLE && cyc_start) begin
      smc_addr <= 32'(cyc_addr);        // Zero-extended
      smc_data <= cyc_wdata;
    end
    if (strobe_last && !cyc_write)
      cyc_rdata <= data_smc;            // End of read strobe
  end

endmodule

/* hw/smc_ahb_slave.sv */
// SMC AHB-lite slave port
`timescale 1ns/1ps

module smc_ahb_slave import smc_pkg::*; #(
  parameter int ADDR_W = 24
) (
  input  logic              hclk,
  input  logic              rst_n,
  input  logic [31:0]       haddr,
  input  logic [1:0]        htrans,
  input  logic              hsel,
  input  logic              hwrite,
  input  logic [2:0]        hsize,
  input  logic [31:0]       hwdata,
  input  logic              hready,     // Muxed bus ready
  input  logic              ctrl_en,
  input  logic              cyc_done,
  input  logic [31:0]       cyc_rdata,
  output logic [31:0]       smc_hrdata,
  output logic              smc_hready,
  output logic [1:0]        smc_hresp,
  output logic              smc_valid,
  output logic              cyc_start,
  output logic              cyc_write,
  output logic [ADDR_W-1:0] cyc_addr,
  output logic [3:0]        cyc_be,
  output logic [31:0]       cyc_wdata,
  output logic              err_pulse
);

  logic        accept;   // Address phase taken this edge
  logic        bad_req;  // Disabled or oversized
  logic        err_ph1;  // First cycle of the ERROR pair
  logic [31:0] wdata_q;

  assign accept  = hsel && hready &&
                   (htrans == TRANS_NONSEQ || htrans == TRANS_SEQ);
  assign bad_req = !ctrl_en || (hsize > SIZE_WORD);

  // Little-endian lane decode
  function automatic logic [3:0] lane_be(input logic [2:0] size, input logic [1:0] a);
    logic [3:0] be;
    case (size)
      SIZE_BYTE: be = 4'b0001 << a;
      SIZE_HALF: be = 4'b0011 << {a[1], 1'b0};
      default:   be = 4'b1111;
    endcase
    return be;
  endfunction

  // ----------------------------------------
  // Response and handshake control
  // ----------------------------------------
  always_ff @(posedge hclk) begin
    if (!rst_n) begin
      smc_hready <= 1'b1;
      smc_hresp  <= RESP_OKAY;
      smc_valid  <= 1'b0;
      cyc_start  <= 1'b0;
      cyc_write  <= 1'b0;
      err_ph1    <= 1'b0;
    end else begin
      smc_valid <= accept;              // One-cycle acknowledge
      cyc_start <= accept && !bad_req;
      err_ph1   <= accept && bad_req;
      if (accept) begin
        smc_hready <= 1'b0;             // Stall the master
        smc_hresp  <= bad_req ? RESP_ERROR : RESP_OKAY;
        cyc_write  <= hwrite;
      end else if (err_ph1) begin
        smc_hready <= 1'b1;             // Second ERROR cycle
      end else if (cyc_done) begin
        smc_hready <= 1'b1;
      end else if (smc_hready) begin
        smc_hresp  <= RESP_OKAY;        // Pair finished
      end
    end
  end

  // Address phase payload
  always_ff @(posedge hclk) begin
    if (accept) begin
      cyc_addr <= haddr[ADDR_W-1:0];
      cyc_be   <= lane_be(hsize, haddr[1:0]);
    end
    if (cyc_start)
      wdata_q <= hwdata;                // Valid only in first data cycle
  end

  // Live bus data while starting, then the held copy
  assign cyc_wdata = cyc_start ? hwdata : wdata_q;

  assign err_pulse  = err_ph1;          // Single pulse per rejected transfer
  assign smc_hrdata = cyc_rdata;        // Held by the sequencer until next read

endmodule

/* hw/smc_apb_regs.sv */
// SMC APB register block
`timescale 1ns/1ps

module smc_apb_regs import smc_pkg::*; (
  input  logic               hclk,
  input  logic               rst_n,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  logic [4:0]         paddr,
  input  logic [31:0]        pwdata,
  input  logic               seq_busy,   // Live sequencer activity
  input  logic               err_pulse,  // One per rejected transfer
  output logic [31:0]        prdata,
  output logic               ctrl_en,
  output logic [SETUP_W-1:0] setup_cyc,
  output logic [WAIT_W-1:0]  rd_wait,
  output logic [WAIT_W-1:0]  wr_wait,
  output logic [HOLD_W-1:0]  hold_cyc
);

  logic       apb_wr;    // Access phase of a write
  logic [7:0] err_cnt;

  assign apb_wr = psel && penable && pwrite;

  // ----------------------------------------
  // Timing and control
  // ----------------------------------------
  always_ff @(posedge hclk) begin
    if (!rst_n) begin
      setup_cyc <= TIMING_RST[SETUP_LSB +: SETUP_W];
      rd_wait   <= TIMING_RST[RD_WAIT_LSB +: WAIT_W];
      wr_wait   <= TIMING_RST[WR_WAIT_LSB +: WAIT_W];
      hold_cyc  <= TIMING_RST[HOLD_LSB +: HOLD_W];
      ctrl_en   <= 1'b1;                // Enabled out of reset
    end else if (apb_wr) begin
      if (paddr == REG_TIMING) begin
        setup_cyc <= pwdata[SETUP_LSB +: SETUP_W];
        rd_wait   <= pwdata[RD_WAIT_LSB +: WAIT_W];
        wr_wait   <= pwdata[WR_WAIT_LSB +: WAIT_W];
        hold_cyc  <= pwdata[HOLD_LSB +: HOLD_W];
      end
      if (paddr == REG_CTRL)
        ctrl_en <= pwdata[0];
    end
  end

  // Saturating error count, a write wins over a new error
  always_ff @(posedge hclk) begin
    if (!rst_n)
      err_cnt <= '0;
    else if (apb_wr && paddr == REG_ERRCNT)
      err_cnt <= '0;
    else if (err_pulse && err_cnt != 8'hFF)
      err_cnt <= err_cnt + 8'd1;
  end

  // ----------------------------------------
  // Readback, decoded straight from paddr
  // ----------------------------------------
  always_comb begin
    prdata = '0;                        // Unmapped offsets
    case (paddr)
      REG_TIMING: begin
        prdata[SETUP_LSB +: SETUP_W]  = setup_cyc;
        prdata[RD_WAIT_LSB +: WAIT_W] = rd_wait;
        prdata[WR_WAIT_LSB +: WAIT_W] = wr_wait;
        prdata[HOLD_LSB +: HOLD_W]    = hold_cyc;
      end
      REG_CTRL:   prdata[0]   = ctrl_en;
      REG_STATUS: prdata[0]   = seq_busy;  // Not stored here
      REG_ERRCNT: prdata[7:0] = err_cnt;
      default:    prdata      = '0;
    endcase
  end

endmodule

/* hw/smc_pkg.sv */
// Static memory controller definitions
package smc_pkg;

  // ----------------------------------------
  // AHB-lite codes
  // ----------------------------------------
  typedef enum logic [1:0] {
    TRANS_IDLE   = 2'b00,
    TRANS_BUSY   = 2'b01,
    TRANS_NONSEQ = 2'b10,
    TRANS_SEQ    = 2'b11
  } smc_trans_e;

  typedef enum logic [1:0] {
    RESP_OKAY  = 2'b00,
    RESP_ERROR = 2'b01
  } smc_resp_e;

  typedef enum logic [2:0] {
    SIZE_BYTE = 3'b000,
    SIZE_HALF = 3'b001,
    SIZE_WORD = 3'b010 // Anything above is rejected
  } smc_size_e;

  // ----------------------------------------
  // APB register map
  // ----------------------------------------
  localparam logic [4:0] REG_TIMING = 5'h00;
  localparam logic [4:0] REG_CTRL   = 5'h04; // Bit 0 enable
  localparam logic [4:0] REG_STATUS = 5'h08; // Bit 0 busy, read only
  localparam logic [4:0] REG_ERRCNT = 5'h0C; // Any write clears

  // Timing field widths
  localparam int SETUP_W = 2;
  localparam int WAIT_W  = 4; // Shared by read and write wait
  localparam int HOLD_W  = 2;

  // Field positions in REG_TIMING
  localparam int SETUP_LSB   = 0;
  localparam int RD_WAIT_LSB = 8;
  localparam int WR_WAIT_LSB = 16;
  localparam int HOLD_LSB    = 24;

  // Setup 1, read wait 2, write wait 1, hold 1
  localparam logic [31:0] TIMING_RST = 32'h0101_0201;

endpackage
